//--- logic/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = '0;

    // major opcodes of the kept instruction groups
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_store  = 7'b0100011;

    typedef enum logic [4:0] {
        NOP, LUI,
        ADD, SUB, SLT, SLTU,
        XOR, OR, AND,
        SLL, SRL, SRA,
        SB, SH, SW,
        INVALID
    } op_e;

    typedef enum logic [2:0] {
        BYPASS_UNIT, ADDER_UNIT, LOGICAL_UNIT, SHIFTER_UNIT, MEMORY_UNIT
    } unit_e;

    function automatic unit_e op_unit(input op_e op);
        case (op)
            ADD, SUB, SLT, SLTU: op_unit = ADDER_UNIT;
            XOR, OR, AND:        op_unit = LOGICAL_UNIT;
            SLL, SRL, SRA:       op_unit = SHIFTER_UNIT;
            SB, SH, SW:          op_unit = MEMORY_UNIT;
            default:             op_unit = BYPASS_UNIT;  // nop, lui, invalid
        endcase
    endfunction

    // ops that produce a value for rd
    function automatic logic op_writes_rd(input op_e op);
        op_writes_rd = (op_unit(op) != MEMORY_UNIT) && (op != NOP) && (op != INVALID);
    endfunction

endpackage

`default_nettype wire

//--- logic/pipe_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// decode -> execute
interface exec_if;
    logic                              valid;
    core_pkg::op_e                     op;
    logic [core_pkg::xlen-1:0]         operand_a;
    logic [core_pkg::xlen-1:0]         operand_b;
    logic [core_pkg::xlen-1:0]         store_data;
    logic [core_pkg::reg_addr_w-1:0]   rd;

    modport decode_mp  (output valid, op, operand_a, operand_b, store_data, rd);
    modport execute_mp (input  valid, op, operand_a, operand_b, store_data, rd);
endinterface

// execute -> retire
interface retire_if;
    logic                              valid;
    core_pkg::op_e                     op;
    logic [core_pkg::xlen-1:0]         result;      // alu value or store address
    logic [core_pkg::xlen-1:0]         store_data;
    logic [core_pkg::reg_addr_w-1:0]   rd;

    modport execute_mp (output valid, op, result, store_data, rd);
    modport retire_mp  (input  valid, op, result, store_data, rd);
endinterface

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall_i,
    input  logic                      hazard_i,
    output logic [core_pkg::xlen-1:0] instruction_address_o,
    output logic [core_pkg::xlen-1:0] pc_o
);

    logic [core_pkg::xlen-1:0] pc_q;   // address of the word now in decode
    logic                      started_q;

    // on a hold the same address goes out again, so the memory repeats the word.
    // the first cycle out of reset always advances to reset_pc
    assign instruction_address_o = (started_q && (stall_i || hazard_i)) ? pc_q : pc_q + 4;
    assign pc_o = pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q      <= core_pkg::reset_pc - 4;
            started_q <= 1'b0;
        end else begin
            pc_q      <= instruction_address_o;
            started_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
    input  logic                            clk,
    input  logic                            wb_enable_i,
    input  logic [core_pkg::reg_addr_w-1:0] rs1_i,
    input  logic [core_pkg::reg_addr_w-1:0] rs2_i,
    input  logic [core_pkg::reg_addr_w-1:0] wb_rd_i,
    input  logic [core_pkg::xlen-1:0]       wb_data_i,
    output logic [core_pkg::xlen-1:0]       rs1_data_o,
    output logic [core_pkg::xlen-1:0]       rs2_data_o
);

    logic [core_pkg::xlen-1:0] regs [1:31];   // x0 is not stored

    always_ff @(posedge clk) begin
        if (wb_enable_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // writeback bypass so decode sees the value retiring this cycle
    assign rs1_data_o = (rs1_i == '0) ? '0 :
                        (wb_enable_i && rs1_i == wb_rd_i) ? wb_data_i : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 :
                        (wb_enable_i && rs2_i == wb_rd_i) ? wb_data_i : regs[rs2_i];

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            stall_i,
    input  logic [core_pkg::xlen-1:0]       instruction_i,
    input  logic [core_pkg::xlen-1:0]       rs1_data_i,
    input  logic [core_pkg::xlen-1:0]       rs2_data_i,
    output logic [core_pkg::reg_addr_w-1:0] rs1_o,
    output logic [core_pkg::reg_addr_w-1:0] rs2_o,
    output logic                            hazard_o,
    exec_if.decode_mp                       ex
);

    logic [6:0]                amount_opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [core_pkg::xlen-1:0] imm_i, imm_s, imm_u;
    logic [core_pkg::xlen-1:0] operand_b;
    core_pkg::op_e             op;
    logic                      uses_rs1, uses_rs2;
    logic                      word_valid_q;   // low while instruction_i predates reset

    assign amount_opcode = instruction_i[6:0];
    assign funct3        = instruction_i[14:12];
    assign funct7        = instruction_i[31:25];
    assign rs1_o         = instruction_i[19:15];
    assign rs2_o         = instruction_i[24:20];

    assign imm_i = {{20{instruction_i[31]}}, instruction_i[31:20]};
    assign imm_s = {{20{instruction_i[31]}}, instruction_i[31:25], instruction_i[11:7]};
    assign imm_u = {instruction_i[31:12], 12'b0};

    always_comb begin
        op        = core_pkg::INVALID;
        operand_b = rs2_data_i;
        case (amount_opcode)
            core_pkg::opcode_lui: begin
                op        = core_pkg::LUI;
                operand_b = imm_u;
            end
            core_pkg::opcode_op_imm: begin
                operand_b = imm_i;
                case (funct3)
                    3'b000:  op = (instruction_i == 32'h0000_0013) ? core_pkg::NOP : core_pkg::ADD;
                    3'b010:  op = core_pkg::SLT;
                    3'b011:  op = core_pkg::SLTU;
                    3'b100:  op = core_pkg::XOR;
                    3'b110:  op = core_pkg::OR;
                    3'b111:  op = core_pkg::AND;
                    3'b001:  op = (funct7 == 7'b0000000) ? core_pkg::SLL : core_pkg::INVALID;
                    default: begin
                        if (funct7 == 7'b0000000) op = core_pkg::SRL;
                        else if (funct7 == 7'b0100000) op = core_pkg::SRA;
                    end
                endcase
            end
            core_pkg::opcode_op: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = core_pkg::ADD;
                    10'b0100000_000: op = core_pkg::SUB;
                    10'b0000000_001: op = core_pkg::SLL;
                    10'b0000000_010: op = core_pkg::SLT;
                    10'b0000000_011: op = core_pkg::SLTU;
                    10'b0000000_100: op = core_pkg::XOR;
                    10'b0000000_101: op = core_pkg::SRL;
                    10'b0100000_101: op = core_pkg::SRA;
                    10'b0000000_110: op = core_pkg::OR;
                    10'b0000000_111: op = core_pkg::AND;
                    default:         op = core_pkg::INVALID;
                endcase
            end
            core_pkg::opcode_store: begin
                operand_b = imm_s;                       // offset, rs2 goes as store data
                case (funct3)
                    3'b000:  op = core_pkg::SB;
                    3'b001:  op = core_pkg::SH;
                    3'b010:  op = core_pkg::SW;
                    default: op = core_pkg::INVALID;
                endcase
            end
            default: op = core_pkg::INVALID;
        endcase
    end

    assign uses_rs1 = (op != core_pkg::NOP) && (op != core_pkg::LUI) && (op != core_pkg::INVALID);
    assign uses_rs2 = ((amount_opcode == core_pkg::opcode_op) && (op != core_pkg::INVALID))
                   || (core_pkg::op_unit(op) == core_pkg::MEMORY_UNIT);

    // result of the instruction in execute is not readable yet
    assign hazard_o = ex.valid && core_pkg::op_writes_rd(ex.op) && (ex.rd != '0)
                   && ((uses_rs1 && rs1_o == ex.rd) || (uses_rs2 && rs2_o == ex.rd));

    always_ff @(posedge clk) begin
        if (reset) begin
            word_valid_q <= 1'b0;
            ex.valid     <= 1'b0;
        end else begin
            word_valid_q <= 1'b1;
            if (!stall_i) begin
                ex.valid <= word_valid_q && !hazard_o;   // bubble on hazard
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ex.op         <= op;
            ex.operand_a  <= rs1_data_i;
            ex.operand_b  <= operand_b;
            ex.store_data <= rs2_data_i;
            ex.rd         <= instruction_i[11:7];
        end
    end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall_i,
    exec_if.execute_mp    ex,
    retire_if.execute_mp  rt
);

    core_pkg::unit_e           unit;
    logic [core_pkg::xlen-1:0] sum, difference, result;
    logic                      less_signed, less_unsigned;
    logic [4:0]                shamt;

    assign unit          = core_pkg::op_unit(ex.op);
    assign sum           = ex.operand_a + ex.operand_b;    // also the store address
    assign difference    = ex.operand_a - ex.operand_b;
    assign less_signed   = $signed(ex.operand_a) < $signed(ex.operand_b);
    assign less_unsigned = ex.operand_a < ex.operand_b;
    assign shamt         = ex.operand_b[4:0];

    always_comb begin
        case (unit)
            core_pkg::ADDER_UNIT: begin
                case (ex.op)
                    core_pkg::ADD:  result = sum;
                    core_pkg::SUB:  result = difference;
                    core_pkg::SLT:  result = {{(core_pkg::xlen-1){1'b0}}, less_signed};
                    default:        result = {{(core_pkg::xlen-1){1'b0}}, less_unsigned};
                endcase
            end
            core_pkg::LOGICAL_UNIT: begin
                case (ex.op)
                    core_pkg::XOR:  result = ex.operand_a ^ ex.operand_b;
                    core_pkg::OR:   result = ex.operand_a | ex.operand_b;
                    default:        result = ex.operand_a & ex.operand_b;
                endcase
            end
            core_pkg::SHIFTER_UNIT: begin
                case (ex.op)
                    core_pkg::SLL:  result = ex.operand_a << shamt;
                    core_pkg::SRL:  result = ex.operand_a >> shamt;
                    default:        result = $unsigned($signed(ex.operand_a) >>> shamt);
                endcase
            end
            core_pkg::MEMORY_UNIT:  result = sum;
            default:                result = ex.operand_b;   // lui immediate
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rt.valid <= 1'b0;
        end else if (!stall_i) begin
            rt.valid <= ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            rt.op         <= ex.op;
            rt.result     <= result;
            rt.store_data <= ex.store_data;
            rt.rd         <= ex.rd;
        end
    end

endmodule

`default_nettype wire

//--- logic/retire_stage.sv
`timescale 1ns/1ps
`default_nettype none

module retire_stage (
    input  logic                            stall_i,
    retire_if.retire_mp                     rt,
    output logic                            wb_enable_o,
    output logic [core_pkg::reg_addr_w-1:0] wb_rd_o,
    output logic [core_pkg::xlen-1:0]       wb_data_o,
    output logic [3:0]                      mem_write_enable_o,
    output logic [core_pkg::xlen-1:0]       mem_address_o,
    output logic [core_pkg::xlen-1:0]       mem_data_o
);

    logic       store_fire;
    logic [3:0] lane_mask;

    assign wb_enable_o = rt.valid && !stall_i && core_pkg::op_writes_rd(rt.op);
    assign wb_rd_o     = rt.rd;
    assign wb_data_o   = rt.result;

    assign store_fire    = rt.valid && !stall_i
                        && (core_pkg::op_unit(rt.op) == core_pkg::MEMORY_UNIT);
    assign mem_address_o = {rt.result[core_pkg::xlen-1:2], 2'b00};   // word aligned

    // byte lanes picked by the low address bits, data replicated across lanes
    always_comb begin
        case (rt.op)
            core_pkg::SB: begin
                lane_mask  = 4'b0001 << rt.result[1:0];
                mem_data_o = {4{rt.store_data[7:0]}};
            end
            core_pkg::SH: begin
                lane_mask  = rt.result[1] ? 4'b1100 : 4'b0011;
                mem_data_o = {2{rt.store_data[15:0]}};
            end
            default: begin
                lane_mask  = 4'b1111;
                mem_data_o = rt.store_data;
            end
        endcase
    end

    assign mem_write_enable_o = store_fire ? lane_mask : 4'b0000;

endmodule

`default_nettype wire

//--- logic/puc_core.sv
`timescale 1ns/1ps
`default_nettype none

module puc_core (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall_i,
    input  logic [core_pkg::xlen-1:0] instruction_i,
    output logic [core_pkg::xlen-1:0] instruction_address_o,
    output logic [core_pkg::xlen-1:0] mem_address_o,
    output logic [core_pkg::xlen-1:0] mem_data_o,
    output logic [3:0]                mem_write_enable_o
);

    logic                            hazard;
    logic [core_pkg::reg_addr_w-1:0] rs1, rs2;
    logic [core_pkg::xlen-1:0]       rs1_data, rs2_data;
    logic                            wb_enable;
    logic [core_pkg::reg_addr_w-1:0] wb_rd;
    logic [core_pkg::xlen-1:0]       wb_data;

    exec_if   ex_bus ();
    retire_if rt_bus ();

    fetch_stage fetch_i (
        .clk(clk), .reset(reset), .stall_i(stall_i), .hazard_i(hazard),
        .instruction_address_o(instruction_address_o),
        .pc_o()                                       // decode pc, debug only
    );

    decode_stage decode_i (
        .clk(clk), .reset(reset), .stall_i(stall_i), .instruction_i(instruction_i),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_o(rs1), .rs2_o(rs2), .hazard_o(hazard), .ex(ex_bus.decode_mp)
    );

    reg_bank reg_bank_i (
        .clk(clk), .wb_enable_i(wb_enable), .rs1_i(rs1), .rs2_i(rs2),
        .wb_rd_i(wb_rd), .wb_data_i(wb_data),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    execute_stage execute_i (
        .clk(clk), .reset(reset), .stall_i(stall_i),
        .ex(ex_bus.execute_mp), .rt(rt_bus.execute_mp)
    );

    retire_stage retire_i (
        .stall_i(stall_i), .rt(rt_bus.retire_mp),
        .wb_enable_o(wb_enable), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .mem_write_enable_o(mem_write_enable_o), .mem_address_o(mem_address_o),
        .mem_data_o(mem_data_o)
    );

endmodule

`default_nettype wire

//--- sim/core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module core_properties (
    input logic                      clk,
    input logic                      reset,
    input logic                      stall_i,
    input logic [core_pkg::xlen-1:0] instruction_address_o,
    input logic [3:0]                mem_write_enable_o
);

    assert property (@(posedge clk) reset |-> mem_write_enable_o == 4'b0000)
        else $error("write enable active during reset");

    assert property (@(posedge clk) $fell(reset) |-> mem_write_enable_o == 4'b0000)
        else $error("write enable active right after reset");

    assert property (@(posedge clk) disable iff (reset) stall_i |-> mem_write_enable_o == 4'b0000)
        else $error("memory write while stalled");

    // single byte, aligned halfword or full word
    assert property (@(posedge clk) disable iff (reset)
        $onehot0(mem_write_enable_o) || mem_write_enable_o == 4'b0011
        || mem_write_enable_o == 4'b1100 || mem_write_enable_o == 4'b1111)
        else $error("illegal byte enable pattern");

    assert property (@(posedge clk) disable iff (reset) !$past(reset) |->
        instruction_address_o[1:0] == 2'b00
        && (instruction_address_o == $past(instruction_address_o)
            || instruction_address_o == $past(instruction_address_o) + 32'd4))
        else $error("instruction address jumped or is unaligned");

endmodule

bind puc_core core_properties core_props_i (
    .clk(clk), .reset(reset), .stall_i(stall_i),
    .instruction_address_o(instruction_address_o),
    .mem_write_enable_o(mem_write_enable_o)
);

`default_nettype wire

//--- sim/tb_puc_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_puc_core;

    logic        clk;
    logic        reset;
    logic        stall_i;
    logic [31:0] instruction_i;
    logic [31:0] instruction_address_o, mem_address_o, mem_data_o;
    logic [3:0]  mem_write_enable_o;

    logic [31:0] prog [$];
    logic [67:0] expected_q [$];      // {write enable, address, data}
    logic [67:0] store_entry;
    logic [31:0] fetch_addr_q;
    int          cycles;

    puc_core dut_i (.*);

    always #5 clk = ~clk;

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic logic [31:0] store_word(input logic [2:0] f3, input logic [4:0] rs2,
                                              input logic [11:0] off);
        return {off[11:5], rs2, 5'd0, f3, off[4:0], core_pkg::opcode_store};
    endfunction

    // sb, sh or sw of a random register to a small aligned offset from x0
    function automatic logic [31:0] random_store();
        logic [2:0]  f3;
        logic [11:0] off;
        f3  = 3'($urandom % 3);
        off = 12'($urandom % 256);
        if (f3 == 3'd1) off = off & 12'hffe;
        if (f3 == 3'd2) off = off & 12'hffc;
        return store_word(f3, 5'($urandom % 8), off);
    endfunction

    function automatic logic [31:0] random_alu();
        logic [4:0]  rd, rs1, rs2, shamt;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        rd    = 5'($urandom % 8);
        rs1   = 5'($urandom % 8);
        rs2   = 5'($urandom % 8);
        shamt = 5'($urandom);
        f3    = 3'($urandom);
        imm   = 12'($urandom);
        f7    = (($urandom % 2) == 0) ? 7'b0100000 : 7'b0000000;
        case ($urandom % 5)
            0: return {20'($urandom), rd, core_pkg::opcode_lui};
            1, 2: begin
                if (f3 == 3'd1) imm = {7'b0, shamt};
                if (f3 == 3'd5) imm = {f7, shamt};     // srli or srai
                return {imm, rs1, f3, rd, core_pkg::opcode_op_imm};
            end
            default: begin
                if (f3 != 3'd0 && f3 != 3'd5) f7 = 7'b0;
                return {f7, rs2, rs1, f3, rd, core_pkg::opcode_op};
            end
        endcase
    endfunction

    // plain rv32i semantics of one register-writing instruction
    function automatic logic [31:0] ref_result(input logic [31:0] w, input logic [31:0] a,
                                               input logic [31:0] rs2_val);
        logic [31:0] b;
        logic        alt;
        if (w[6:0] == core_pkg::opcode_lui) return {w[31:12], 12'b0};
        b   = (w[6:0] == core_pkg::opcode_op) ? rs2_val : {{20{w[31]}}, w[31:20]};
        alt = w[30];
        case (w[14:12])
            3'd0: return (alt && w[6:0] == core_pkg::opcode_op) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void build_expected();
        logic [31:0] regs [0:31];
        logic [31:0] w, addr, v, lanes;
        logic [3:0]  we;
        int          nbytes, first;
        for (int r = 0; r < 32; r++) regs[r] = '0;
        foreach (prog[i]) begin
            w = prog[i];
            if (w[6:0] == core_pkg::opcode_store) begin
                addr   = regs[w[19:15]] + {{20{w[31]}}, w[31:25], w[11:7]};
                v      = regs[w[24:20]];
                nbytes = 1 << w[13:12];          // sb, sh, sw
                first  = int'(addr[1:0]);
                // each lane repeats the matching byte of the stored value
                for (int k = 0; k < 4; k++) begin
                    we[k]           = (k >= first) && (k < first + nbytes);
                    lanes[8*k +: 8] = v[8*(k % nbytes) +: 8];
                end
                expected_q.push_back({we, addr[31:2], 2'b00, lanes});
            end else if (w[11:7] != 5'd0) begin
                regs[w[11:7]] = ref_result(w, regs[w[19:15]], regs[w[24:20]]);
            end
        end
    endfunction

    always @(posedge clk) fetch_addr_q <= instruction_address_o;

    always @(negedge clk) begin   // memory answers one cycle after the address
        if (int'(fetch_addr_q[31:2]) < prog.size()) instruction_i = prog[fetch_addr_q[31:2]];
        else instruction_i = 32'h0000_0013;
    end

    always @(posedge clk) begin
        if (!reset && mem_write_enable_o != 4'b0000) begin
            if (expected_q.size() == 0) begin
                $display("unexpected store to %h at %0t", mem_address_o, $time);
                $display(">>> FAIL");
                $fatal(1, "extra store");
            end else begin
                store_entry = expected_q.pop_front();
                check("write enable", {28'b0, mem_write_enable_o}, {28'b0, store_entry[67:64]});
                check("store address", mem_address_o, store_entry[63:32]);
                check("store data", mem_data_o, store_entry[31:0]);
            end
        end
    end

    initial begin
        void'($urandom(32'hb0b3cf99));
        clk           = 1'b0;
        reset         = 1'b1;
        stall_i       = 1'b0;
        instruction_i = 32'h0000_0013;
        for (int r = 1; r < 8; r++) prog.push_back({12'($urandom), 5'd0, 3'd0, 5'(r), 7'h13});
        for (int i = 0; i < 200; i++) begin
            prog.push_back(random_alu());
            if ($urandom % 4 == 0) begin
                prog.push_back(random_store());
            end
        end
        for (int r = 1; r < 8; r++) prog.push_back(store_word(3'd2, 5'(r), 12'(512 + 4 * r)));
        for (int i = 0; i < 8; i++) prog.push_back(32'h0000_0013);
        build_expected();
        repeat (8) @(negedge clk);
        reset  = 1'b0;
        cycles = 0;
        while (expected_q.size() != 0) begin
            @(negedge clk);
            stall_i = ($urandom % 5 == 0);
            cycles++;
            if (cycles > 5000) begin
                $display("timeout: %0d expected stores never arrived", expected_q.size());
                $display(">>> FAIL");
                $fatal(1, "timeout");
            end
        end
        stall_i = 1'b0;
        repeat (20) @(negedge clk);   // catch any extra store
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- puc_core.f
logic/core_pkg.sv
logic/pipe_ifs.sv
logic/fetch_stage.sv
logic/reg_bank.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/retire_stage.sv
logic/puc_core.sv
sim/core_properties.sv
sim/tb_puc_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_puc_core \
    -f puc_core.f -o tb_puc_core

if ! ./obj_dir/tb_puc_core > sim.log 2>&1; then
    echo "simulation exited with an error status"
fi

if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
exit 0
